// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = thor_iq_tb
FILELIST  = files.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

# Pass only when the simulation prints the pass line
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJDIR)

// File: files.f
hw/thor_iq_pkg.sv
hw/thor_livetarget.sv
hw/thor_iq_alloc.sv
hw/thor_latest_writer.sv
hw/thor_iq_top.sv
testbench/thor_iq_assertions.sv
testbench/thor_iq_tb.sv

// File: hw/thor_iq_alloc.sv
// Queue entry bookkeeping; dispatch at the tail, commit from the head, flush stomping by age
module thor_iq_alloc
	import thor_iq_pkg::*;
(
	input  logic      clk,
	input  logic      rst,

	// Dispatch in
	input  logic      dispatch_valid,
	input  dispatch_t dispatch,
	output logic      dispatch_ready,

	// Commit out
	output logic      commit_valid,
	output commit_t   commit,
	input  logic      commit_ready,

	// Branch flush
	input  logic      flush,
	input  iq_tag_t   flush_tag,

	// Entry state
	output iq_mask_t  entry_valid,
	output iq_mask_t  entry_stomp,
	output reg_idx_t  entry_tgt [QENTRIES],
	output iq_tag_t   head
);

	iq_mask_t valid_q;
	iq_mask_t valid_nxt;
	reg_idx_t tgt_q [QENTRIES];
	iq_tag_t  head_q;
	iq_tag_t  tail_q;
	iq_tag_t  tail_nxt;
	iq_cnt_t  count;
	iq_cnt_t  count_nxt;

	iq_mask_t stomp;
	iq_tag_t  flush_off;

	logic do_disp;
	logic do_commit;

	////////////////////////////////////////////////////////////
	// Handshakes
	////////////////////////////////////////////////////////////

	// No dispatch while full or during a mispredict
	assign dispatch_ready = (count != iq_cnt_t'(QENTRIES)) && !flush;
	assign do_disp = dispatch_valid && dispatch_ready;

	assign commit_valid = valid_q[head_q];
	assign commit.tag = head_q;
	assign commit.tgt = tgt_q[head_q];
	assign do_commit = commit_valid && commit_ready;

	////////////////////////////////////////////////////////////
	// Stomp by age
	////////////////////////////////////////////////////////////

	// Ages measured from the head, so a full queue needs no special case
	assign flush_off = flush_tag - head_q;

	always_comb begin
		iq_tag_t entry_off;
		for (int e = 0; e < QENTRIES; e++) begin
			entry_off = iq_tag_t'(e) - head_q;
			stomp[e] = flush && valid_q[e] && (entry_off > flush_off);
		end
	end

	////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////

	always_comb begin
		valid_nxt = valid_q & ~stomp;
		if (do_commit) begin
			valid_nxt[head_q] = 1'b0;
		end
		if (do_disp) begin
			valid_nxt[tail_q] = 1'b1;
		end
	end

	always_comb begin
		if (flush) begin
			// Survivors run from the head through flush_tag
			tail_nxt = flush_tag + iq_tag_t'(1);
			count_nxt = {1'b0, flush_off} + iq_cnt_t'(1) - iq_cnt_t'(do_commit);
		end else begin
			tail_nxt = tail_q + iq_tag_t'(do_disp);
			count_nxt = count + iq_cnt_t'(do_disp) - iq_cnt_t'(do_commit);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
			head_q <= '0;
			tail_q <= '0;
			count <= '0;
		end else begin
			valid_q <= valid_nxt;
			tail_q <= tail_nxt;
			count <= count_nxt;
			if (do_commit) begin
				head_q <= head_q + iq_tag_t'(1);
			end
		end
	end

	// Target storage
	always_ff @(posedge clk) begin
		if (do_disp) begin
			tgt_q[tail_q] <= dispatch.tgt;
		end
	end

	assign entry_valid = valid_q;
	assign entry_stomp = stomp;
	assign entry_tgt = tgt_q;
	assign head = head_q;

endmodule

// File: hw/thor_iq_pkg.sv
// Shared sizes, vector types and handshake payloads for the issue-queue register-tracking logic
package thor_iq_pkg;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////

	// Queue entries, age wraps modulo this
	localparam int QENTRIES = 8;

	// Architectural registers, register 0 means no destination
	localparam int NREGS = 288;

	localparam int TAG_W = $clog2(QENTRIES);
	localparam int REG_W = $clog2(NREGS);

	////////////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////////////

	// Entry index
	typedef logic [TAG_W-1:0] iq_tag_t;

	// Occupancy, 0 up to QENTRIES inclusive
	typedef logic [TAG_W:0] iq_cnt_t;

	// Register number
	typedef logic [REG_W-1:0] reg_idx_t;

	// One bit per queue entry
	typedef logic [QENTRIES-1:0] iq_mask_t;

	// One bit per target register, bit 0 left out
	typedef logic [NREGS-1:1] reg_mask_t;

	////////////////////////////////////////////////////////////
	// Handshake payloads
	////////////////////////////////////////////////////////////

	typedef struct packed {
		reg_idx_t tgt;
	} dispatch_t;

	typedef struct packed {
		iq_tag_t  tag;
		reg_idx_t tgt;
	} commit_t;

endpackage

// File: hw/thor_iq_top.sv
// Issue-queue register tracking top; allocation, live-target masks and the writer lookup port
module thor_iq_top
	import thor_iq_pkg::*;
(
	input  logic      clk,
	input  logic      rst,

	input  logic      dispatch_valid,
	input  dispatch_t dispatch,
	output logic      dispatch_ready,

	output logic      commit_valid,
	output commit_t   commit,
	input  logic      commit_ready,

	input  logic      flush,
	input  iq_tag_t   flush_tag,

	input  reg_idx_t  query_reg,
	output logic      query_busy,
	output iq_tag_t   query_tag,

	output reg_mask_t livetarget
);

	iq_mask_t  entry_valid;
	iq_mask_t  entry_stomp;
	reg_idx_t  entry_tgt [QENTRIES];
	iq_tag_t   head;
	reg_mask_t entry_livetarget [QENTRIES];

	thor_iq_alloc u_alloc (
		.clk            (clk),
		.rst            (rst),
		.dispatch_valid (dispatch_valid),
		.dispatch       (dispatch),
		.dispatch_ready (dispatch_ready),
		.commit_valid   (commit_valid),
		.commit         (commit),
		.commit_ready   (commit_ready),
		.flush          (flush),
		.flush_tag      (flush_tag),
		.entry_valid    (entry_valid),
		.entry_stomp    (entry_stomp),
		.entry_tgt      (entry_tgt),
		.head           (head)
	);

	thor_livetarget u_livetarget (
		.entry_valid      (entry_valid),
		.entry_stomp      (entry_stomp),
		.entry_tgt        (entry_tgt),
		.entry_livetarget (entry_livetarget),
		.livetarget       (livetarget)
	);

	thor_latest_writer u_latest_writer (
		.entry_livetarget (entry_livetarget),
		.head             (head),
		.query_reg        (query_reg),
		.query_busy       (query_busy),
		.query_tag        (query_tag)
	);

endmodule

// File: hw/thor_latest_writer.sv
// Writer lookup for one register; reports whether it is pending and the youngest live writer
module thor_latest_writer
	import thor_iq_pkg::*;
(
	input  reg_mask_t entry_livetarget [QENTRIES],
	input  iq_tag_t   head,
	input  reg_idx_t  query_reg,
	output logic      query_busy,
	output iq_tag_t   query_tag
);

	////////////////////////////////////////////////////////////
	// Per-entry hit
	////////////////////////////////////////////////////////////

	// Register 0 and out of range numbers have no mask bit
	logic     reg_ok;
	iq_mask_t hit;

	assign reg_ok = (query_reg != '0) && (query_reg < reg_idx_t'(NREGS));

	always_comb begin
		for (int e = 0; e < QENTRIES; e++) begin
			if (reg_ok) begin
				hit[e] = entry_livetarget[e][query_reg];
			end else begin
				hit[e] = 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Age-ordered scan
	////////////////////////////////////////////////////////////

	// Oldest first, later hits overwrite so the youngest wins
	always_comb begin
		iq_tag_t idx;
		query_busy = 1'b0;
		query_tag = '0;
		for (int i = 0; i < QENTRIES; i++) begin
			idx = head + iq_tag_t'(i);
			if (hit[idx]) begin
				query_busy = 1'b1;
				query_tag = idx;
			end
		end
	end

endmodule

// File: hw/thor_livetarget.sv
// Live-target masks per entry and combined; feeds the pending mask and the writer lookup
module thor_livetarget
	import thor_iq_pkg::*;
(
	input  iq_mask_t  entry_valid,
	input  iq_mask_t  entry_stomp,
	input  reg_idx_t  entry_tgt [QENTRIES],
	output reg_mask_t entry_livetarget [QENTRIES],
	output reg_mask_t livetarget
);

	////////////////////////////////////////////////////////////
	// Per-entry decode
	////////////////////////////////////////////////////////////

	// Entry still counts as a writer
	iq_mask_t entry_live;

	// Full one-hot including register 0
	logic [NREGS-1:0] decoded [QENTRIES];

	assign entry_live = entry_valid & ~entry_stomp;

	genvar e;
	generate
		for (e = 0; e < QENTRIES; e = e + 1) begin : g_entry
			// Out of range targets shift out to zero
			assign decoded[e] = {{(NREGS-1){1'b0}}, 1'b1} << entry_tgt[e];

			// Drop bit 0 so "no destination" never shows up
			assign entry_livetarget[e] = decoded[e][NREGS-1:1] & {(NREGS-1){entry_live[e]}};
		end
	endgenerate

	////////////////////////////////////////////////////////////
	// Combined pending mask
	////////////////////////////////////////////////////////////

	// Register pending while any live entry writes it
	always_comb begin
		livetarget = '0;
		for (int i = 0; i < QENTRIES; i++) begin
			livetarget = livetarget | entry_livetarget[i];
		end
	end

endmodule

// File: testbench/thor_iq_assertions.sv
// Concurrent checks on occupancy, head survival across a flush and commit; bound into the allocator
module thor_iq_assertions
	import thor_iq_pkg::*;
(
	input logic     clk,
	input logic     rst,
	input iq_cnt_t  count,
	input logic     dispatch_ready,
	input logic     commit_valid,
	input logic     commit_ready,
	input logic     flush,
	input iq_tag_t  head,
	input iq_mask_t entry_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	int fails = 0;

	// Full queue takes nothing
	full_blocks_dispatch: assert property (@(posedge clk) disable iff (rst)
		(&entry_valid) |-> !dispatch_ready)
	else begin
		$error("dispatch_ready high with every entry valid");
		fails++;
	end

	// Head is never younger than the flush point
	head_not_stomped: assert property (@(posedge clk) disable iff (rst)
		(flush && !commit_ready) |=> entry_valid[head])
	else begin
		$error("head entry lost across a flush");
		fails++;
	end

	// Head offered exactly while entries are held
	commit_needs_valid: assert property (@(posedge clk) disable iff (rst)
		commit_valid == (count != '0))
	else begin
		$error("commit_valid disagrees with the entry count");
		fails++;
	end

endmodule

bind thor_iq_alloc thor_iq_assertions u_assertions (
	.clk            (clk),
	.rst            (rst),
	.count          (count),
	.dispatch_ready (dispatch_ready),
	.commit_valid   (commit_valid),
	.commit_ready   (commit_ready),
	.flush          (flush),
	.head           (head_q),
	.entry_valid    (valid_q)
);

// File: testbench/thor_iq_tb.sv
// Self-checking testbench for the issue-queue tracking top; directed table, then random traffic
module thor_iq_tb
	import thor_iq_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	typedef enum int {OP_IDLE, OP_DISP, OP_COMMIT, OP_FLUSH} op_e;

	typedef struct {
		string name;
		op_e   op;
		int    operand;
		int    qreg;
		bit    busy;
		int    tag;
	} row_t;

	localparam int N_RAND = 300;

	logic      clk;
	logic      rst;
	logic      dispatch_valid;
	dispatch_t dispatch;
	logic      dispatch_ready;
	logic      commit_valid;
	commit_t   commit;
	logic      commit_ready;
	logic      flush;
	iq_tag_t   flush_tag;
	reg_idx_t  query_reg;
	logic      query_busy;
	iq_tag_t   query_tag;
	reg_mask_t livetarget;

	row_t table_q[$];

	// Reference queue
	int m_tgt [QENTRIES];
	int m_head;
	int m_tail;
	int m_count;

	int mismatches = 0;
	int other_errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycle_limit = 0;

	thor_iq_top UUT (
		.clk            (clk),
		.rst            (rst),
		.dispatch_valid (dispatch_valid),
		.dispatch       (dispatch),
		.dispatch_ready (dispatch_ready),
		.commit_valid   (commit_valid),
		.commit         (commit),
		.commit_ready   (commit_ready),
		.flush          (flush),
		.flush_tag      (flush_tag),
		.query_reg      (query_reg),
		.query_busy     (query_busy),
		.query_tag      (query_tag),
		.livetarget     (livetarget)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Test FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic add_row(string name, op_e op, int operand, int qreg, bit busy, int tag);
		row_t r;
		r.name = name;
		r.op = op;
		r.operand = operand;
		r.qreg = qreg;
		r.busy = busy;
		r.tag = tag;
		table_q.push_back(r);
	endtask

	task automatic report_mismatch(string name, string field, string exp_s, string act_s);
		$display("mismatch %s %s expected %s actual %s", name, field, exp_s, act_s);
		mismatches++;
	endtask

	// Entry still writes its target in the current cycle
	function automatic bit model_live(int e, bit fl, int ftag);
		int off;
		off = (e - m_head) & (QENTRIES - 1);
		if (off >= m_count) begin
			return 1'b0;
		end
		if (fl && off > ((ftag - m_head) & (QENTRIES - 1))) begin
			return 1'b0;
		end
		return 1'b1;
	endfunction

	task automatic run_cycle(string name, op_e op, int operand, int qreg, bit with_commit,
			bit has_exp, bit tbl_busy, int tbl_tag);
		bit        fl;
		bit        exp_ready;
		bit        exp_cvalid;
		bit        exp_busy;
		int        exp_tag;
		int        e;
		reg_mask_t exp_lt;

		@(posedge clk);
		dispatch_valid <= (op == OP_DISP);
		dispatch.tgt <= reg_idx_t'(operand);
		commit_ready <= (op == OP_COMMIT) || (op == OP_FLUSH && with_commit);
		flush <= (op == OP_FLUSH);
		flush_tag <= iq_tag_t'(operand);
		query_reg <= reg_idx_t'(qreg);

		// Mid-cycle, outputs are settled
		@(negedge clk);
		fl = (op == OP_FLUSH);
		exp_ready = (m_count < QENTRIES) && !fl;
		exp_cvalid = (m_count > 0);
		exp_busy = 1'b0;
		exp_tag = 0;
		exp_lt = '0;
		for (int o = 0; o < QENTRIES; o++) begin
			e = (m_head + o) & (QENTRIES - 1);
			if (model_live(e, fl, operand) && m_tgt[e] != 0) begin
				exp_lt[m_tgt[e]] = 1'b1;
				if (m_tgt[e] == qreg) begin
					exp_busy = 1'b1;
					exp_tag = e;
				end
			end
		end

		if (has_exp && (tbl_busy != exp_busy || tbl_tag != exp_tag)) begin
			$display("table row %s disagrees with the reference model (busy %0b tag %0d)",
				name, exp_busy, exp_tag);
			other_errors++;
		end
		checks++;
		if (dispatch_ready !== exp_ready) begin
			report_mismatch(name, "dispatch_ready", $sformatf("%0b", exp_ready),
				$sformatf("%0b", dispatch_ready));
		end
		if (commit_valid !== exp_cvalid) begin
			report_mismatch(name, "commit_valid", $sformatf("%0b", exp_cvalid),
				$sformatf("%0b", commit_valid));
		end
		if (exp_cvalid && commit.tag !== iq_tag_t'(m_head)) begin
			report_mismatch(name, "commit.tag", $sformatf("%0d", m_head),
				$sformatf("%0d", commit.tag));
		end
		if (exp_cvalid && commit.tgt !== reg_idx_t'(m_tgt[m_head])) begin
			report_mismatch(name, "commit.tgt", $sformatf("%0d", m_tgt[m_head]),
				$sformatf("%0d", commit.tgt));
		end
		if (livetarget !== exp_lt) begin
			report_mismatch(name, "livetarget", $sformatf("%h", exp_lt),
				$sformatf("%h", livetarget));
		end
		if (query_busy !== exp_busy) begin
			report_mismatch(name, "query_busy", $sformatf("%0b", exp_busy),
				$sformatf("%0b", query_busy));
		end
		if (query_tag !== iq_tag_t'(exp_tag)) begin
			report_mismatch(name, "query_tag", $sformatf("%0d", exp_tag),
				$sformatf("%0d", query_tag));
		end

		// Model follows what the DUT takes at the next edge
		if (fl) begin
			m_count = ((operand - m_head) & (QENTRIES - 1)) + 1;
			m_tail = (operand + 1) & (QENTRIES - 1);
		end
		if (op == OP_DISP && exp_ready) begin
			m_tgt[m_tail] = operand;
			m_tail = (m_tail + 1) & (QENTRIES - 1);
			m_count++;
		end
		if ((op == OP_COMMIT || (fl && with_commit)) && exp_cvalid) begin
			m_head = (m_head + 1) & (QENTRIES - 1);
			m_count--;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed rows
	////////////////////////////////////////////////////////////

	task automatic load_table();
		add_row("reset_idle", OP_IDLE, 0, 5, 0, 0);
		add_row("disp_5", OP_DISP, 5, 5, 0, 0);
		add_row("disp_9", OP_DISP, 9, 5, 1, 0);
		add_row("disp_5b", OP_DISP, 5, 9, 1, 1);
		add_row("disp_0", OP_DISP, 0, 5, 1, 2);
		add_row("query_0", OP_IDLE, 0, 0, 0, 0);
		add_row("query_5", OP_IDLE, 0, 5, 1, 2);
		add_row("commit_0", OP_COMMIT, 0, 5, 1, 2);
		add_row("commit_1", OP_COMMIT, 0, 9, 1, 1);
		add_row("after_commit", OP_IDLE, 0, 9, 0, 0);
		add_row("disp_7", OP_DISP, 7, 7, 0, 0);
		add_row("disp_5c", OP_DISP, 5, 7, 1, 4);
		add_row("disp_7b", OP_DISP, 7, 5, 1, 5);
		add_row("flush_3", OP_FLUSH, 3, 5, 1, 2);
		add_row("post_flush", OP_IDLE, 0, 7, 0, 0);
		add_row("disp_11", OP_DISP, 11, 11, 0, 0);
		add_row("check_11", OP_IDLE, 0, 11, 1, 4);
		add_row("fill_20", OP_DISP, 20, 20, 0, 0);
		add_row("fill_21", OP_DISP, 21, 20, 1, 5);
		add_row("fill_22", OP_DISP, 22, 21, 1, 6);
		add_row("fill_23", OP_DISP, 23, 22, 1, 7);
		add_row("fill_24", OP_DISP, 24, 23, 1, 0);
		add_row("full_offer", OP_DISP, 30, 24, 1, 1);
		add_row("full_offer2", OP_DISP, 30, 30, 0, 0);
		add_row("free_one", OP_COMMIT, 0, 5, 1, 2);
		add_row("disp_30", OP_DISP, 30, 5, 0, 0);
		add_row("check_30", OP_IDLE, 0, 30, 1, 2);
		add_row("flush_head", OP_FLUSH, 3, 30, 0, 0);
		add_row("after_head", OP_IDLE, 0, 11, 0, 0);
	endtask

	initial begin
		int  pick;
		int  operand;
		int  qr;
		op_e op;

		void'($urandom(41488));
		clk = 1'b0;
		rst = 1'b1;
		dispatch_valid = 1'b0;
		dispatch = '0;
		commit_ready = 1'b0;
		flush = 1'b0;
		flush_tag = '0;
		query_reg = '0;
		m_head = 0;
		m_tail = 0;
		m_count = 0;
		foreach (m_tgt[i]) begin
			m_tgt[i] = 0;
		end
		load_table();
		cycle_limit = (table_q.size() + N_RAND) * 4 + 50;

		repeat (8) @(posedge clk);
		rst <= 1'b0;

		foreach (table_q[i]) begin
			run_cycle(table_q[i].name, table_q[i].op, table_q[i].operand, table_q[i].qreg,
				1'b0, 1'b1, table_q[i].busy, table_q[i].tag);
		end

		// Random traffic, tags wrap many times
		for (int n = 0; n < N_RAND; n++) begin
			pick = int'($urandom % 8);
			operand = 0;
			if (pick < 4) begin
				op = OP_DISP;
				if ($urandom % 4 == 0) begin
					operand = int'($urandom % NREGS);
				end else begin
					operand = int'($urandom % 12);
				end
			end else if (pick < 6) begin
				op = OP_COMMIT;
			end else if (pick == 6 && m_count > 0) begin
				op = OP_FLUSH;
				operand = (m_head + int'($urandom % m_count)) & (QENTRIES - 1);
			end else begin
				op = OP_IDLE;
			end
			if ($urandom % 2 == 0) begin
				qr = int'($urandom % 12);
			end else begin
				qr = m_tgt[$urandom % QENTRIES];
			end
			run_cycle($sformatf("rand_%0d", n), op, operand, qr, bit'($urandom % 2),
				1'b0, 1'b0, 0);
		end

		@(posedge clk);
		dispatch_valid <= 1'b0;
		commit_ready <= 1'b0;
		flush <= 1'b0;
		@(posedge clk);

		other_errors += UUT.u_alloc.u_assertions.fails;
		$display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches,
			other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
